// ==== list.f ====
+incdir+include
verilog/stq_pkg.sv
verilog/stq_if.sv
verilog/stq_entry_array.sv
verilog/stq_load_check.sv
verilog/stq_chk_merge.sv
verilog/stq_top.sv
testbench/stq_tb_clk.sv
testbench/stq_assert.sv
testbench/stq_tb.sv

// ==== Bender.yml ====
package:
  name: stq

export_include_dirs:
  - include

sources:
  - verilog/stq_pkg.sv
  - verilog/stq_if.sv
  - verilog/stq_entry_array.sv
  - verilog/stq_load_check.sv
  - verilog/stq_chk_merge.sv
  - verilog/stq_top.sv
  - target: test
    files:
      - testbench/stq_tb_clk.sv
      - testbench/stq_assert.sv
      - testbench/stq_tb.sv

// ==== testbench/stq_tb.sv ====
`timescale 1ns/100ps
`include "stq_macros.svh"

module stq_tb;
  import stq_pkg::*;

  localparam int D = `STQ_DEPTH;
  localparam int L = `STQ_LANES;

  logic clk;
  logic rst;
  logic wrt_en;
  stq_addr_t wrt_addr;
  stq_mask_t wrt_mask;
  logic upd_en;
  stq_idx_t upd_idx;
  stq_data_t upd_data;
  logic ret_en;
  logic [L-1:0] chk_en;
  stq_addr_t [L-1:0] chk_addr;
  stq_mask_t [L-1:0] chk_mask;
  stq_idx_t [L-1:0] chk_tail;
  logic full;
  stq_idx_t tail;
  logic wb_en;
  stq_addr_t wb_addr;
  stq_mask_t wb_mask;
  stq_data_t wb_data;
  logic [L-1:0] chk_valid;
  fwd_res_t [L-1:0] chk_res;
  stq_data_t [L-1:0] chk_data;
  logic chk_stall;

  // shadow queue state after the last edge
  logic m_valid [D];
  logic m_rdy [D];
  stq_addr_t m_addr [D];
  stq_mask_t m_mask [D];
  stq_data_t m_data [D];
  int m_head;
  int m_tail;
  logic have_exp; // expected values for the next edge below
  logic e_wb;
  stq_addr_t e_wb_addr;
  stq_mask_t e_wb_mask;
  stq_data_t e_wb_data;
  logic [L-1:0] e_valid;
  fwd_res_t e_res [L];
  stq_data_t e_data [L];
  logic e_stall;
  int err_ctl, err_res, err_data, err_wb, err_tmo;
  logic [31:0] lcg_state;
  logic [31:0] r;

  stq_tb_clk u_clk (.clk(clk), .rst(rst));
  stq_top dut0 (.*);

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 8; // low bits cycle too fast
  endfunction

  function automatic stq_idx_t wrap_idx(int i);
    return stq_idx_t'(i % D);
  endfunction

  function automatic int m_count();
    int n;
    n = 0;
    for (int i = 0; i < D; i++) if (m_valid[i]) n++;
    return n;
  endfunction

  // youngest older overlapping store decides
  function automatic fwd_res_t ref_check(input stq_addr_t addr, input stq_mask_t mask,
                                         input stq_idx_t ld_tail, output stq_data_t data);
    int n;
    int idx;
    data = '0;
    n = (int'(ld_tail) - m_head + D) % D;
    for (int k = 1; k <= n; k++) begin
      idx = (int'(ld_tail) - k + D) % D;
      if (m_valid[idx] && m_addr[idx] == addr && (m_mask[idx] & mask) != 0) begin
        if ((m_mask[idx] & mask) == mask && m_rdy[idx]) begin
          data = m_data[idx];
          return FWD_HIT;
        end
        return FWD_STALL;
      end
    end
    return FWD_MISS;
  endfunction

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      err_ctl++;
      $display("ERROR %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic check_idx(input string name, input stq_idx_t got, input stq_idx_t exp);
    if (got !== exp) begin
      err_ctl++;
      $display("ERROR %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic check_res(input string name, input fwd_res_t got, input fwd_res_t exp);
    if (got !== exp) begin
      err_res++;
      $display("ERROR %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic check_data(input string name, input stq_data_t got, input stq_data_t exp);
    if (got !== exp) begin
      err_data++;
      $display("ERROR %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic check_wb(input stq_addr_t a, input stq_mask_t m, input stq_data_t d,
                          input stq_addr_t ea, input stq_mask_t em, input stq_data_t ed);
    if (a !== ea || m !== em || d !== ed) begin
      err_wb++;
      $display("ERROR wb_addr/wb_mask/wb_data got %h/%h/%h exp %h/%h/%h", a, m, d, ea, em, ed);
    end
  endtask

  task automatic compare_outputs();
    check_bit("wb_en", wb_en, e_wb);
    if (e_wb) check_wb(wb_addr, wb_mask, wb_data, e_wb_addr, e_wb_mask, e_wb_data);
    check_bit("chk_stall", chk_stall, e_stall);
    for (int l = 0; l < L; l++) begin
      check_bit($sformatf("chk_valid[%0d]", l), chk_valid[l], e_valid[l]);
      if (e_valid[l]) check_res($sformatf("chk_res[%0d]", l), chk_res[l], e_res[l]);
      if (e_valid[l] && e_res[l] != FWD_STALL)
        check_data($sformatf("chk_data[%0d]", l), chk_data[l], e_data[l]);
    end
    check_bit("full", full, m_count() == D);
    check_idx("tail", tail, wrap_idx(m_tail));
  endtask

  // predict the coming edge and step the shadow queue
  task automatic predict_and_step();
    stq_data_t d;
    int h;
    h = m_head;
    e_stall = 1'b0;
    for (int l = 0; l < L; l++) begin
      e_valid[l] = chk_en[l];
      e_res[l] = ref_check(chk_addr[l], chk_mask[l], chk_tail[l], d);
      e_data[l] = d;
      if (chk_en[l] && e_res[l] == FWD_STALL) e_stall = 1'b1;
    end
    e_wb = ret_en && m_valid[h] && m_rdy[h];
    e_wb_addr = m_addr[h];
    e_wb_mask = m_mask[h];
    e_wb_data = m_data[h];
    if (wrt_en && m_count() < D) begin
      m_valid[m_tail] = 1'b1;
      m_rdy[m_tail] = 1'b0;
      m_addr[m_tail] = wrt_addr;
      m_mask[m_tail] = wrt_mask;
      m_tail = (m_tail + 1) % D;
    end
    if (upd_en) begin
      m_data[upd_idx] = upd_data;
      m_rdy[upd_idx] = 1'b1;
    end
    if (e_wb) begin
      m_valid[h] = 1'b0;
      m_head = (h + 1) % D;
    end
  endtask

  always @(negedge clk) begin
    if (have_exp) compare_outputs();
    if (rst) begin
      for (int i = 0; i < D; i++) begin
        m_valid[i] = 1'b0;
        m_rdy[i] = 1'b0;
      end
      m_head = 0;
      m_tail = 0;
      e_wb = 1'b0;
      e_valid = '0;
      e_stall = 1'b0;
    end else begin
      predict_and_step();
    end
    have_exp = 1'b1;
  end

  task automatic cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic idle_inputs();
    wrt_en = 1'b0;
    wrt_addr = '0;
    wrt_mask = '0;
    upd_en = 1'b0;
    upd_idx = '0;
    upd_data = '0;
    ret_en = 1'b0;
    chk_en = '0;
    chk_addr = '0;
    chk_mask = '0;
    chk_tail = '0;
  endtask

  task automatic push_store(input stq_addr_t a, input stq_mask_t m);
    wrt_en = 1'b1;
    wrt_addr = a;
    wrt_mask = m;
    cycle();
    wrt_en = 1'b0;
  endtask

  task automatic fill_data(input stq_idx_t i, input stq_data_t d);
    upd_en = 1'b1;
    upd_idx = i;
    upd_data = d;
    cycle();
    upd_en = 1'b0;
  endtask

  task automatic retire_head();
    ret_en = 1'b1;
    cycle();
    ret_en = 1'b0;
  endtask

  task automatic issue_check(input int l, input stq_addr_t a, input stq_mask_t m,
                             input stq_idx_t t);
    chk_en[l] = 1'b1;
    chk_addr[l] = a;
    chk_mask[l] = m;
    chk_tail[l] = t;
    cycle();
    chk_en[l] = 1'b0;
  endtask

  task automatic wait_reset_done();
    int n;
    n = 0;
    while (rst !== 1'b0 && n < 10) begin
      cycle();
      n++;
    end
    if (rst !== 1'b0) begin
      err_tmo++;
      $display("timeout: reset was never released");
    end
  endtask

  task automatic wait_wb(input int limit);
    int n;
    n = 0;
    while (!wb_en && n < limit) begin
      cycle();
      n++;
    end
    if (!wb_en) begin
      err_tmo++;
      $display("timeout: no writeback pulse after a retire of a ready head");
    end
  endtask

  // give every entry data and retire them all
  task automatic drain();
    int n;
    n = 0;
    while (m_count() > 0 && n < 4 * D) begin
      if (!m_rdy[m_head]) fill_data(wrap_idx(m_head), lcg_next());
      retire_head();
      n++;
    end
    if (m_count() > 0) begin
      err_tmo++;
      $display("timeout: the queue did not drain");
    end
  endtask

  initial begin
    int base;
    int total;
    idle_inputs();
    have_exp = 1'b0;
    lcg_state = 32'd23;
    {err_ctl, err_res, err_data, err_wb, err_tmo} = '0;
    wait_reset_done();
    issue_check(0, 16'h0001, 4'hF, 4'd0); // empty queue misses
    for (int i = 0; i < D; i++) push_store(stq_addr_t'(16'h0040 + i), 4'hF);
    push_store(16'h00FF, 4'hF); // ignored since the queue is full
    drain();
    push_store(16'h0055, 4'h3);
    retire_head(); // head has no data so no pulse
    fill_data(wrap_idx(m_head), 32'hCAFE_0001);
    retire_head();
    wait_wb(4);
    base = m_tail;
    push_store(16'h0100, 4'hF);
    fill_data(wrap_idx(base), 32'h1111_0000);
    push_store(16'h0100, 4'hF);
    fill_data(wrap_idx(base + 1), 32'h2222_0000);
    issue_check(0, 16'h0100, 4'h3, wrap_idx(base + 1)); // younger store not older than load
    issue_check(1, 16'h0100, 4'hC, wrap_idx(base + 2));
    push_store(16'h0200, 4'h3);
    fill_data(wrap_idx(base + 2), 32'h3333_0000);
    issue_check(0, 16'h0200, 4'hF, wrap_idx(base + 3)); // partial overlap
    push_store(16'h0200, 4'hF);
    issue_check(1, 16'h0200, 4'hF, wrap_idx(base + 4)); // covering but no data
    fill_data(wrap_idx(base + 3), 32'h4444_0000);
    issue_check(0, 16'h0200, 4'hF, wrap_idx(base + 4)); // shadows the partial one
    drain();
    for (int c = 0; c < 400; c++) begin
      r = lcg_next();
      wrt_en = r[0] | r[1];
      wrt_addr = stq_addr_t'(16'h0010 + r[3:2]);
      wrt_mask = (r[7:4] == 4'h0) ? 4'h1 : r[7:4];
      upd_en = r[8];
      upd_idx = wrap_idx(m_head + int'(r[12:9]) % (m_count() + 1));
      upd_data = lcg_next();
      ret_en = r[13] & r[14];
      for (int l = 0; l < L; l++) begin
        r = lcg_next();
        chk_en[l] = r[0];
        chk_addr[l] = stq_addr_t'(16'h0010 + r[2:1]);
        chk_mask[l] = (r[6:3] == 4'h0) ? 4'hF : r[6:3];
        chk_tail[l] = wrap_idx(m_head + int'(r[11:7]) % (m_count() + 1));
      end
      cycle();
    end
    idle_inputs();
    cycle();
    cycle();
    total = err_ctl + err_res + err_data + err_wb + err_tmo;
    $display("errors: ctl=%0d res=%0d data=%0d wb=%0d timeout=%0d",
             err_ctl, err_res, err_data, err_wb, err_tmo);
    if (total == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== testbench/stq_assert.sv ====
`timescale 1ns/100ps
`include "stq_macros.svh"

module stq_assert (
  input logic                               clk,
  input logic                               rst,
  input logic                               wrt_en,
  input logic                               ret_en,
  input logic                               full,
  input stq_pkg::stq_idx_t                  tail,
  input logic                               wb_en,
  input logic [`STQ_LANES-1:0]              chk_valid,
  input stq_pkg::fwd_res_t [`STQ_LANES-1:0] chk_res,
  input logic                               chk_stall
);
  import stq_pkg::*;

  function automatic logic any_stall(logic [`STQ_LANES-1:0] v,
                                     fwd_res_t [`STQ_LANES-1:0] r);
    logic s;
    s = 1'b0;
    for (int i = 0; i < `STQ_LANES; i++) begin
      if (v[i] && r[i] == FWD_STALL) s = 1'b1;
    end
    return s;
  endfunction

  // each writeback pulse needs its own retire
  a_wb_retire: assert property (@(posedge clk) disable iff (rst) wb_en |-> $past(ret_en))
    else $error("wb_en high without a retire in the cycle before");

  a_full_write: assert property (@(posedge clk) disable iff (rst)
    full && wrt_en |=> tail == $past(tail))
    else $error("write accepted while the queue was full");

  a_stall_src: assert property (@(posedge clk) disable iff (rst)
    chk_stall |-> any_stall(chk_valid, chk_res))
    else $error("chk_stall high with no lane reporting a stall");

endmodule

bind stq_top stq_assert u_assert (
  .clk       (clk),
  .rst       (rst),
  .wrt_en    (wrt_en),
  .ret_en    (ret_en),
  .full      (full),
  .tail      (tail),
  .wb_en     (wb_en),
  .chk_valid (chk_valid),
  .chk_res   (chk_res),
  .chk_stall (chk_stall)
);

// ==== testbench/stq_tb_clk.sv ====
`timescale 1ns/100ps

module stq_tb_clk (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk; // 40 ns period
  end

  initial begin
    rst = 1'b1;
    repeat (2) @(posedge clk);
    #2 rst = 1'b0; // same offset as the stimulus
  end

endmodule

// ==== verilog/stq_top.sv ====
`timescale 1ns/100ps
`include "stq_macros.svh"

module stq_top (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  wrt_en,
  input  stq_pkg::stq_addr_t                    wrt_addr,
  input  stq_pkg::stq_mask_t                    wrt_mask,
  input  logic                                  upd_en,
  input  stq_pkg::stq_idx_t                     upd_idx,
  input  stq_pkg::stq_data_t                    upd_data,
  input  logic                                  ret_en,
  input  logic [`STQ_LANES-1:0]                 chk_en,
  input  stq_pkg::stq_addr_t [`STQ_LANES-1:0]   chk_addr,
  input  stq_pkg::stq_mask_t [`STQ_LANES-1:0]   chk_mask,
  input  stq_pkg::stq_idx_t [`STQ_LANES-1:0]    chk_tail,
  output logic                                  full,
  output stq_pkg::stq_idx_t                     tail,
  output logic                                  wb_en,
  output stq_pkg::stq_addr_t                    wb_addr,
  output stq_pkg::stq_mask_t                    wb_mask,
  output stq_pkg::stq_data_t                    wb_data,
  output logic [`STQ_LANES-1:0]                 chk_valid,
  output stq_pkg::fwd_res_t [`STQ_LANES-1:0]    chk_res,
  output stq_pkg::stq_data_t [`STQ_LANES-1:0]   chk_data,
  output logic                                  chk_stall
);

  stq_entry_if ent_if ();
  stq_chk_if chk_if [`STQ_LANES] (); // one per lane

  stq_entry_array u_array (
    .clk      (clk),
    .rst      (rst),
    .wrt_en   (wrt_en),
    .wrt_addr (wrt_addr),
    .wrt_mask (wrt_mask),
    .upd_en   (upd_en),
    .upd_idx  (upd_idx),
    .upd_data (upd_data),
    .ret_en   (ret_en),
    .full     (full),
    .tail     (tail),
    .wb_en    (wb_en),
    .wb_addr  (wb_addr),
    .wb_mask  (wb_mask),
    .wb_data  (wb_data),
    .ent      (ent_if.array)
  );

  // all lanes share the same view of the queue
  for (genvar g = 0; g < `STQ_LANES; g++) begin : g_lane
    stq_load_check u_chk (
      .en      (chk_en[g]),
      .addr    (chk_addr[g]),
      .mask    (chk_mask[g]),
      .ld_tail (chk_tail[g]),
      .ent     (ent_if.lane),
      .res_o   (chk_if[g].lane)
    );
  end

  stq_chk_merge u_merge (
    .clk       (clk),
    .rst       (rst),
    .lanes     (chk_if),
    .chk_valid (chk_valid),
    .chk_res   (chk_res),
    .chk_data  (chk_data),
    .chk_stall (chk_stall)
  );

endmodule

// ==== verilog/stq_chk_merge.sv ====
`timescale 1ns/100ps
`include "stq_macros.svh"

module stq_chk_merge (
  input  logic                                  clk,
  input  logic                                  rst,
  stq_chk_if.merge                              lanes [`STQ_LANES],
  output logic [`STQ_LANES-1:0]                 chk_valid,
  output stq_pkg::fwd_res_t [`STQ_LANES-1:0]    chk_res,
  output stq_pkg::stq_data_t [`STQ_LANES-1:0]   chk_data,
  output logic                                  chk_stall
);
  import stq_pkg::*;

  logic [`STQ_LANES-1:0] lane_en;
  fwd_res_t [`STQ_LANES-1:0] lane_res;
  stq_data_t [`STQ_LANES-1:0] lane_data;
  logic [`STQ_LANES-1:0] lane_stall;

  for (genvar g = 0; g < `STQ_LANES; g++) begin : g_lane
    assign lane_en[g] = lanes[g].en;
    assign lane_res[g] = lanes[g].res;
    assign lane_data[g] = lanes[g].data;
    assign lane_stall[g] = lanes[g].en && (lanes[g].res == FWD_STALL);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      chk_valid <= '0;
      chk_stall <= 1'b0;
    end else begin
      chk_valid <= lane_en;
      chk_stall <= |lane_stall; // any enabled lane that must wait
    end
  end

  always_ff @(posedge clk) begin
    chk_res <= lane_res;
    chk_data <= lane_data;
  end

endmodule

// ==== verilog/stq_load_check.sv ====
`timescale 1ns/100ps
`include "stq_macros.svh"

module stq_load_check (
  input  logic               en,
  input  stq_pkg::stq_addr_t addr,
  input  stq_pkg::stq_mask_t mask,
  input  stq_pkg::stq_idx_t  ld_tail,
  stq_entry_if.lane          ent,
  stq_chk_if.lane            res_o
);
  import stq_pkg::*;

  logic [`STQ_DEPTH-1:0] older;
  logic [`STQ_DEPTH-1:0] ovl;
  int win;
  logic found;
  stq_idx_t sel;
  logic covers;

  // circular distance from one index forward to another
  function automatic int circ_dist(stq_idx_t from, stq_idx_t to);
    if (to >= from) begin
      return int'(to) - int'(from);
    end
    return int'(to) + `STQ_DEPTH - int'(from);
  endfunction

  assign win = circ_dist(ent.head, ld_tail); // ld_tail == head means no older store

  always_comb begin
    for (int i = 0; i < `STQ_DEPTH; i++) begin
      older[i] = ent.valid[i] && (circ_dist(ent.head, stq_idx_t'(i)) < win);
      ovl[i] = older[i] && (ent.addr[i] == addr) && |(ent.mask[i] & mask);
    end
  end

  // walk back from the load's tail, first overlap is the youngest
  always_comb begin
    int j;
    found = 1'b0;
    sel = '0;
    for (int k = 1; k <= `STQ_DEPTH; k++) begin
      j = int'(ld_tail) - k;
      if (j < 0) begin
        j = j + `STQ_DEPTH;
      end
      if (!found && ovl[j]) begin
        found = 1'b1;
        sel = stq_idx_t'(j);
      end
    end
  end

  assign covers = (ent.mask[sel] & mask) == mask;

  always_comb begin
    res_o.res = FWD_MISS;
    res_o.data = '0;
    if (found) begin
      if (covers && ent.data_rdy[sel]) begin
        res_o.res = FWD_HIT;
        res_o.data = ent.data[sel];
      end else begin
        res_o.res = FWD_STALL; // partial overlap or data not there yet
      end
    end
  end

  assign res_o.en = en;

endmodule

// ==== verilog/stq_entry_array.sv ====
`timescale 1ns/100ps
`include "stq_macros.svh"

module stq_entry_array (
  input  logic               clk,
  input  logic               rst,
  input  logic               wrt_en,
  input  stq_pkg::stq_addr_t wrt_addr,
  input  stq_pkg::stq_mask_t wrt_mask,
  input  logic               upd_en,
  input  stq_pkg::stq_idx_t  upd_idx,
  input  stq_pkg::stq_data_t upd_data,
  input  logic               ret_en,
  output logic               full,
  output stq_pkg::stq_idx_t  tail,
  output logic               wb_en,
  output stq_pkg::stq_addr_t wb_addr,
  output stq_pkg::stq_mask_t wb_mask,
  output stq_pkg::stq_data_t wb_data,
  stq_entry_if.array         ent
);
  import stq_pkg::*;

  logic [`STQ_DEPTH-1:0] valid;
  logic [`STQ_DEPTH-1:0] data_rdy;
  stq_addr_t [`STQ_DEPTH-1:0] addr;
  stq_mask_t [`STQ_DEPTH-1:0] mask;
  stq_data_t [`STQ_DEPTH-1:0] data;
  stq_idx_t head;
  logic wr_ok;
  logic ret_ok;

  // pointer step with wrap at the queue depth
  function automatic stq_idx_t idx_inc(stq_idx_t i);
    if (i == stq_idx_t'(`STQ_DEPTH - 1)) begin
      return '0;
    end
    return i + 1'b1;
  endfunction

  assign full = &valid;
  assign wr_ok = wrt_en && !full; // write while full is dropped
  assign ret_ok = ret_en && valid[head] && data_rdy[head];

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;
      data_rdy <= '0;
      head <= '0;
      tail <= '0;
      wb_en <= 1'b0;
    end else begin
      if (wr_ok) begin
        valid[tail] <= 1'b1;
        data_rdy[tail] <= 1'b0; // data comes later by index
        tail <= idx_inc(tail);
      end
      if (upd_en) begin
        data_rdy[upd_idx] <= 1'b1;
      end
      if (ret_ok) begin
        valid[head] <= 1'b0;
        head <= idx_inc(head);
      end
      wb_en <= ret_ok; // single cycle pulse
    end
  end

  always_ff @(posedge clk) begin
    if (wr_ok) begin
      addr[tail] <= wrt_addr;
      mask[tail] <= wrt_mask;
    end
    if (upd_en) begin
      data[upd_idx] <= upd_data;
    end
    if (ret_ok) begin
      wb_addr <= addr[head];
      wb_mask <= mask[head];
      wb_data <= data[head];
    end
  end

  assign ent.valid = valid;
  assign ent.data_rdy = data_rdy;
  assign ent.addr = addr;
  assign ent.mask = mask;
  assign ent.data = data;
  assign ent.head = head;

endmodule

// ==== verilog/stq_if.sv ====
`timescale 1ns/100ps
`include "stq_macros.svh"

// queue state as seen by the load check lanes
interface stq_entry_if;
  import stq_pkg::*;

  logic [`STQ_DEPTH-1:0] valid;
  logic [`STQ_DEPTH-1:0] data_rdy;
  stq_addr_t [`STQ_DEPTH-1:0] addr;
  stq_mask_t [`STQ_DEPTH-1:0] mask;
  stq_data_t [`STQ_DEPTH-1:0] data;
  stq_idx_t head; // oldest entry

  modport array (output valid, data_rdy, addr, mask, data, head);
  modport lane (input valid, data_rdy, addr, mask, data, head);

endinterface

// one lane result, before the merge register
interface stq_chk_if;
  import stq_pkg::*;

  logic en;
  fwd_res_t res;
  stq_data_t data;

  modport lane (output en, res, data);
  modport merge (input en, res, data);

endinterface

// ==== verilog/stq_pkg.sv ====
`include "stq_macros.svh"

package stq_pkg;

  // entry index, also used for head/tail pointers
  typedef logic [`STQ_IDX_W-1:0] stq_idx_t;

  typedef logic [`STQ_ADDR_W-1:0] stq_addr_t;

  typedef logic [`STQ_DATA_W-1:0] stq_data_t;

  typedef logic [`STQ_MASK_W-1:0] stq_mask_t;

  // outcome of a load check
  typedef enum logic [1:0] {
    FWD_MISS  = 2'd0, // no older overlapping store
    FWD_HIT   = 2'd1, // forward from youngest older store
    FWD_STALL = 2'd2  // overlap that cannot be forwarded yet
  } fwd_res_t;

endpackage

// ==== include/stq_macros.svh ====
`ifndef STQ_MACROS_SVH
`define STQ_MACROS_SVH

`define STQ_DEPTH  16 // store entries
`define STQ_IDX_W  4
`define STQ_LANES  2  // load check lanes

`define STQ_ADDR_W 16 // word address
`define STQ_DATA_W 32
`define STQ_MASK_W 4  // one bit per byte

`endif
